//--- list.f
hdl/tlb_pkg.sv
hdl/cp0_pkg.sv
hdl/tlb_array.sv
hdl/tlb_search.sv
hdl/cp0_tlb_regs.sv
hdl/tlb_mmu_top.sv
testbench/tb_clock.sv
testbench/tlb_mmu_asserts.sv
testbench/tb_tlb_mmu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log
set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tlb_mmu --Mdir "$obj_dir" -o tb_tlb_mmu -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$obj_dir/tb_tlb_mmu" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$log"; then
    exit 0
fi

echo "pass line not found in $log"
exit 1

//--- testbench/tb_tlb_mmu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_tlb_mmu;

    import tlb_pkg::*;
    import cp0_pkg::*;

    localparam int tlb_n       = 16;
    localparam int idx_w       = $clog2(tlb_n);
    localparam int period_ns   = 8;
    localparam int reset_cyc   = 16;
    localparam int n_reg       = 40;
    localparam int n_rounds    = 6;
    localparam int n_beats     = 8;
    localparam int n_wr        = tlb_n + 3;
    localparam int n_probe     = 12;
    localparam int total_ops   = 6 + 2 * n_reg + 5 * tlb_n + n_rounds * (n_beats + 1)
                               + 4 * n_wr + 5 * tlb_n + 1 + 3 * n_probe;
    localparam int watchdog_ns = (total_ops * 4 + reset_cyc) * period_ns;

    logic        aclk;
    logic        rst_n;
    cp0_wr_t     cp0_wr;
    cp0_reg_e    cp0_rd_addr;
    logic [31:0] cp0_rd_data;
    logic        tlb_cmd_valid;
    tlb_op_e     tlb_cmd_op;
    logic        tlb_busy;
    tlb_req_t    fetch_req;
    tlb_req_t    data_req;
    tlb_res_t    fetch_res;
    tlb_res_t    data_res;

    // reference model
    tlb_entry_t  model_tlb [tlb_n];
    logic [31:0] m_index;
    logic [31:0] m_entryhi;
    logic [31:0] m_lo0;
    logic [31:0] m_lo1;
    int          m_random;

    logic [31:0] rand_state = 32'd67;
    int          checks = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    cp0_reg_e    reg_list [5] = '{cp0_index, cp0_random, cp0_entrylo0, cp0_entrylo1, cp0_entryhi};

    tb_clock #(
        .period_ns    (period_ns),
        .reset_cycles (reset_cyc)
    ) clk_gen (
        .aclk  (aclk),
        .rst_n (rst_n)
    );

    tlb_mmu_top #(
        .tlb_entries (tlb_n)
    ) uut (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .cp0_wr        (cp0_wr),
        .cp0_rd_addr   (cp0_rd_addr),
        .cp0_rd_data   (cp0_rd_data),
        .tlb_cmd_valid (tlb_cmd_valid),
        .tlb_cmd_op    (tlb_cmd_op),
        .tlb_busy      (tlb_busy),
        .fetch_req     (fetch_req),
        .data_req      (data_req),
        .fetch_res     (fetch_res),
        .data_res      (data_res)
    );

    function automatic logic [31:0] rand_word();
        logic [15:0] hi;
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        hi = rand_state[31:16];
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return {hi, rand_state[31:16]};
    endfunction

    // half the keyed picks reuse a stored vpn2
    function automatic vpn2_t pick_vpn2(input bit keyed);
        logic [31:0] r;
        r = rand_word();
        if (keyed && r[31]) begin
            return model_tlb[r[idx_w-1:0]].vpn2;
        end
        return r[18:0] | 19'h1;
    endfunction

    function automatic tlb_res_t model_lookup(input vpn2_t vpn2, input logic odd, input asid_t a);
        tlb_res_t  r;
        tlb_page_t pg;
        r = '0;
        r.valid = 1'b1;
        for (int i = 0; i < tlb_n; i++) begin
            if (!r.found && model_tlb[i].vpn2 == vpn2 &&
                (model_tlb[i].g || model_tlb[i].asid == a)) begin
                pg      = odd ? model_tlb[i].odd : model_tlb[i].even;
                r.found = 1'b1;
                r.index = 8'(i);
                r.pfn   = pg.pfn;
                r.c     = pg.c;
                r.d     = pg.d;
                r.v     = pg.v;
            end
        end
        return r;
    endfunction

    function automatic tlb_entry_t entry_from_regs();
        tlb_entry_t e;
        e.vpn2 = m_entryhi[31:13];
        e.asid = m_entryhi[7:0];
        e.g    = m_lo0[0] & m_lo1[0];
        e.even = '{pfn: m_lo0[25:6], c: m_lo0[5:3], d: m_lo0[2], v: m_lo0[1]};
        e.odd  = '{pfn: m_lo1[25:6], c: m_lo1[5:3], d: m_lo1[2], v: m_lo1[1]};
        return e;
    endfunction

    function automatic logic [31:0] model_read(input cp0_reg_e addr);
        case (addr)
            cp0_index:    return m_index;
            cp0_random:   return 32'(m_random);
            cp0_entrylo0: return m_lo0;
            cp0_entrylo1: return m_lo1;
            cp0_entryhi:  return m_entryhi;
            default:      return 32'h0;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic check_res(input string name, input tlb_res_t exp, input tlb_res_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic write_cp0(input cp0_reg_e addr, input logic [31:0] data);
        case (addr)
            cp0_index:    m_index   = data & (32'h8000_0000 | 32'(tlb_n - 1));
            cp0_entryhi:  m_entryhi = data & 32'hffff_e0ff;
            cp0_entrylo0: m_lo0     = data & 32'h03ff_ffff;
            cp0_entrylo1: m_lo1     = data & 32'h03ff_ffff;
            default: ;
        endcase
        cp0_wr.we   = 1'b1;
        cp0_wr.addr = addr;
        cp0_wr.data = data;
        next_cycle();
        cp0_wr.we = 1'b0;
    endtask

    task automatic read_cp0(input cp0_reg_e addr, input string name);
        logic [31:0] exp;
        exp = model_read(addr);
        cp0_rd_addr = addr;
        next_cycle();
        check_word(name, exp, cp0_rd_data);
    endtask

    task automatic issue_cmd(input tlb_op_e op);
        tlb_entry_t e;
        case (op)
            tlbwi: model_tlb[m_index[idx_w-1:0]] = entry_from_regs();
            tlbwr: begin
                model_tlb[m_random] = entry_from_regs();
                m_random = (m_random == 0) ? tlb_n - 1 : m_random - 1;
            end
            tlbr: begin
                e = model_tlb[m_index[idx_w-1:0]];
                m_entryhi = {e.vpn2, 5'b0, e.asid};
                m_lo0 = {6'b0, e.even.pfn, e.even.c, e.even.d, e.even.v, e.g};
                m_lo1 = {6'b0, e.odd.pfn, e.odd.c, e.odd.d, e.odd.v, e.g};
            end
            default: ;
        endcase
        tlb_cmd_valid = 1'b1;
        tlb_cmd_op    = op;
        next_cycle();
        tlb_cmd_valid = 1'b0;
    endtask

    task automatic run_probe(input string name);
        tlb_res_t r;
        r = model_lookup(m_entryhi[31:13], 1'b0, m_entryhi[7:0]);
        m_index = r.found ? 32'(r.index) : 32'h8000_0000;
        tlb_cmd_valid = 1'b1;
        tlb_cmd_op    = tlbp;
        next_cycle();
        tlb_cmd_valid = 1'b0;
        if (tlb_busy !== 1'b1) begin
            other_errors++;
            $display("error: tlb_busy did not rise after tlbp in %s", name);
        end
        for (int w = 0; w < 4 && tlb_busy === 1'b1; w++) begin
            next_cycle();
        end
        if (tlb_busy !== 1'b0) begin
            other_errors++;
            $display("error: tlb_busy stuck high after tlbp in %s", name);
        end
        read_cp0(cp0_index, name);
    endtask

    // both ports searched in one cycle, results checked at the next edge
    task automatic search_beat(input string name, input bit keyed);
        logic [31:0] r;
        tlb_req_t    f;
        tlb_req_t    d;
        tlb_res_t    exp_f;
        tlb_res_t    exp_d;
        r = rand_word();
        f.valid = 1'b1;
        f.vpn2  = pick_vpn2(keyed);
        f.odd   = r[0];
        d.valid = 1'b1;
        d.vpn2  = pick_vpn2(keyed);
        d.odd   = r[1];
        exp_f = model_lookup(f.vpn2, f.odd, m_entryhi[7:0]);
        exp_d = model_lookup(d.vpn2, d.odd, m_entryhi[7:0]);
        fetch_req = f;
        data_req  = d;
        next_cycle();
        check_res({name, " fetch"}, exp_f, fetch_res);
        check_res({name, " data"}, exp_d, data_res);
    endtask

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        #(watchdog_ns);
        other_errors++;
        $display("error: watchdog expired after %0d ns before the tests finished", watchdog_ns);
        finish_run();
    end

    initial begin
        logic [31:0] r;
        logic [31:0] hi;
        cp0_reg_e    a;
        vpn2_t       key;
        asid_t       key_asid;
        tlb_res_t    pr;

        cp0_wr        = '0;
        cp0_rd_addr   = cp0_index;
        tlb_cmd_valid = 1'b0;
        tlb_cmd_op    = tlbwi;
        fetch_req     = '0;
        data_req      = '0;
        for (int i = 0; i < tlb_n; i++) begin
            model_tlb[i] = '0;
        end
        m_index   = '0;
        m_entryhi = '0;
        m_lo0     = '0;
        m_lo1     = '0;
        m_random  = tlb_n - 1;

        wait (rst_n === 1'b1);
        next_cycle();

        // reset values
        for (int i = 0; i < 5; i++) begin
            read_cp0(reg_list[i], $sformatf("reset %s", reg_list[i].name()));
        end
        search_beat("reset search", 1'b0);
        fetch_req = '0;
        data_req  = '0;

        // move-to and move-from, random stays read-only
        for (int i = 0; i < n_reg; i++) begin
            r = rand_word();
            a = reg_list[r % 5];
            write_cp0(a, rand_word());
            read_cp0(a, $sformatf("move-from %s %0d", a.name(), i));
        end

        // fill with tlbwi, small vpn2 and asid pools give shared keys
        for (int i = 0; i < tlb_n; i++) begin
            r  = rand_word();
            hi = rand_word();
            if (r[0]) begin
                hi[31:13] = 19'h1200 + 19'(r[2:1]);
            end
            if (r[3]) begin
                hi[7:0] = 8'h3c;
            end
            write_cp0(cp0_entryhi, hi);
            write_cp0(cp0_entrylo0, rand_word());
            write_cp0(cp0_entrylo1, rand_word());
            write_cp0(cp0_index, 32'(i));
            issue_cmd(tlbwi);
        end
        for (int k = 0; k < n_rounds; k++) begin
            r  = rand_word();
            hi = rand_word();
            hi[7:0] = r[0] ? model_tlb[r[idx_w:1]].asid : r[15:8];
            write_cp0(cp0_entryhi, hi);
            for (int b = 0; b < n_beats; b++) begin
                search_beat($sformatf("tlbwi search %0d.%0d", k, b), 1'b1);
            end
            fetch_req = '0;
            data_req  = '0;
        end

        // tlbwr walks down from random and wraps
        for (int w = 0; w < n_wr; w++) begin
            write_cp0(cp0_entryhi, rand_word());
            write_cp0(cp0_entrylo0, rand_word());
            write_cp0(cp0_entrylo1, rand_word());
            issue_cmd(tlbwr);
        end
        for (int k = 0; k < tlb_n; k++) begin
            write_cp0(cp0_index, 32'(k));
            issue_cmd(tlbr);
            read_cp0(cp0_entryhi, $sformatf("tlbr %0d entryhi", k));
            read_cp0(cp0_entrylo0, $sformatf("tlbr %0d entrylo0", k));
            read_cp0(cp0_entrylo1, $sformatf("tlbr %0d entrylo1", k));
        end
        read_cp0(cp0_random, "random after tlbwr");

        // even probes hit a stored key, odd ones miss
        for (int p = 0; p < n_probe; p++) begin
            r        = rand_word();
            key      = r[31:13];
            key_asid = r[7:0];
            if (p % 2 == 0) begin
                key = model_tlb[r[idx_w-1:0]].vpn2;
                if (!model_tlb[r[idx_w-1:0]].g) begin
                    key_asid = model_tlb[r[idx_w-1:0]].asid;
                end
            end else begin
                pr = model_lookup(key, 1'b0, key_asid);
                while (pr.found) begin
                    key = key + 19'd1;
                    pr  = model_lookup(key, 1'b0, key_asid);
                end
            end
            write_cp0(cp0_entryhi, {key, 5'b0, key_asid});
            run_probe($sformatf("tlbp %0d index", p));
        end

        finish_run();
    end

endmodule

`default_nettype wire

//--- testbench/tlb_mmu_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_mmu_asserts (
    input wire logic             aclk,
    input wire logic             rst_n,
    input wire cp0_pkg::cp0_wr_t cp0_wr,
    input wire logic             tlb_cmd_valid,
    input wire logic             tlb_busy
);

    // nothing new while the probe is in flight
    no_issue_while_busy: assert property (
        @(posedge aclk) disable iff (!rst_n)
        tlb_busy |-> (!tlb_cmd_valid && !cp0_wr.we)
    ) else $error("command or move-to issued while tlb_busy is high");

    // probe takes exactly one extra cycle
    busy_single_cycle: assert property (
        @(posedge aclk) disable iff (!rst_n)
        tlb_busy |=> !tlb_busy
    ) else $error("tlb_busy high for two cycles in a row");

    one_issue_per_cycle: assert property (
        @(posedge aclk) disable iff (!rst_n)
        !(tlb_cmd_valid && cp0_wr.we)
    ) else $error("command and move-to issued in the same cycle");

endmodule

bind cp0_tlb_regs tlb_mmu_asserts asserts (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .cp0_wr        (cp0_wr),
    .tlb_cmd_valid (tlb_cmd_valid),
    .tlb_busy      (tlb_busy)
);

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 16
) (
    output logic aclk,
    output logic rst_n
);

    initial begin
        aclk = 1'b0;
        forever begin
            #(period_ns / 2.0) aclk = ~aclk;
        end
    end

    // released on a clock edge, the DUT samples reset synchronously
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge aclk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/tlb_mmu_top.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_mmu_top #(
    parameter int tlb_entries = 16
) (
    input  wire logic              aclk,
    input  wire logic              rst_n,
    input  wire cp0_pkg::cp0_wr_t  cp0_wr,
    input  wire cp0_pkg::cp0_reg_e cp0_rd_addr,
    output logic [31:0]            cp0_rd_data,
    input  wire logic              tlb_cmd_valid,
    input  wire cp0_pkg::tlb_op_e  tlb_cmd_op,
    output logic                   tlb_busy,
    input  wire tlb_pkg::tlb_req_t fetch_req,
    input  wire tlb_pkg::tlb_req_t data_req,
    output tlb_pkg::tlb_res_t      fetch_res,
    output tlb_pkg::tlb_res_t      data_res
);

    import tlb_pkg::*;

    localparam int idx_w = $clog2(tlb_entries);

    logic             we;
    logic [idx_w-1:0] w_index;
    tlb_entry_t       w_entry;
    logic [idx_w-1:0] r_index;
    tlb_entry_t       r_entry;
    tlb_entry_t       entries [tlb_entries];
    asid_t            asid;
    tlb_req_t         probe_req;
    tlb_res_t         probe_res;

    cp0_tlb_regs #(
        .tlb_entries (tlb_entries)
    ) regs (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .cp0_wr        (cp0_wr),
        .cp0_rd_addr   (cp0_rd_addr),
        .cp0_rd_data   (cp0_rd_data),
        .tlb_cmd_valid (tlb_cmd_valid),
        .tlb_cmd_op    (tlb_cmd_op),
        .tlb_busy      (tlb_busy),
        .asid          (asid),
        .we            (we),
        .w_index       (w_index),
        .w_entry       (w_entry),
        .r_index       (r_index),
        .r_entry       (r_entry),
        .probe_req     (probe_req),
        .probe_res     (probe_res)
    );

    tlb_array #(
        .tlb_entries (tlb_entries)
    ) array (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .we      (we),
        .w_index (w_index),
        .w_entry (w_entry),
        .r_index (r_index),
        .r_entry (r_entry),
        .entries (entries)
    );

    // instruction fetch port
    tlb_search #(
        .tlb_entries (tlb_entries)
    ) fetch_search (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .entries (entries),
        .asid    (asid),
        .req     (fetch_req),
        .res     (fetch_res)
    );

    tlb_search #(
        .tlb_entries (tlb_entries)
    ) data_search (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .entries (entries),
        .asid    (asid),
        .req     (data_req),
        .res     (data_res)
    );

    // tlbp lookup, keyed from entryhi
    tlb_search #(
        .tlb_entries (tlb_entries)
    ) probe_search (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .entries (entries),
        .asid    (asid),
        .req     (probe_req),
        .res     (probe_res)
    );

endmodule

`default_nettype wire

//--- hdl/cp0_tlb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_tlb_regs #(
    parameter int tlb_entries = 16
) (
    input  wire logic                           aclk,
    input  wire logic                           rst_n,
    input  wire cp0_pkg::cp0_wr_t               cp0_wr,
    input  wire cp0_pkg::cp0_reg_e              cp0_rd_addr,
    output logic [31:0]                         cp0_rd_data,
    input  wire logic                           tlb_cmd_valid,
    input  wire cp0_pkg::tlb_op_e               tlb_cmd_op,
    output logic                                tlb_busy,
    output tlb_pkg::asid_t                      asid,
    output logic                                we,
    output logic [$clog2(tlb_entries)-1:0]      w_index,
    output tlb_pkg::tlb_entry_t                 w_entry,
    output logic [$clog2(tlb_entries)-1:0]      r_index,
    input  wire tlb_pkg::tlb_entry_t            r_entry,
    output tlb_pkg::tlb_req_t                   probe_req,
    input  wire tlb_pkg::tlb_res_t              probe_res
);

    import tlb_pkg::*;
    import cp0_pkg::*;

    localparam int idx_w = $clog2(tlb_entries);

    logic             index_p;
    logic [idx_w-1:0] index_idx;
    logic [idx_w-1:0] random_q;
    logic [31:0]      entryhi_q;
    logic [31:0]      entrylo0_q;
    logic [31:0]      entrylo1_q;
    logic             probe_pending;

    logic             index_p_n;
    logic [idx_w-1:0] index_idx_n;
    logic [idx_w-1:0] random_n;
    logic [31:0]      entryhi_n;
    logic [31:0]      entrylo0_n;
    logic [31:0]      entrylo1_n;
    logic [31:0]      rd_next;

    assign asid     = entryhi_q[7:0];
    assign tlb_busy = probe_pending;

    // tlbwi and tlbwr share the write port
    assign we      = tlb_cmd_valid && (tlb_cmd_op == tlbwi || tlb_cmd_op == tlbwr);
    assign w_index = (tlb_cmd_op == tlbwr) ? random_q : index_idx;
    assign r_index = index_idx;

    always_comb begin
        w_entry.vpn2 = entryhi_q[31:13];
        w_entry.asid = entryhi_q[7:0];
        w_entry.g    = entrylo0_q[0] & entrylo1_q[0];
        w_entry.even = entrylo0_q[25:1];
        w_entry.odd  = entrylo1_q[25:1];
    end

    always_comb begin
        probe_req.valid = tlb_cmd_valid && (tlb_cmd_op == tlbp);
        probe_req.vpn2  = entryhi_q[31:13];
        probe_req.odd   = 1'b0;
    end

    always_comb begin
        index_p_n   = index_p;
        index_idx_n = index_idx;
        random_n    = random_q;
        entryhi_n   = entryhi_q;
        entrylo0_n  = entrylo0_q;
        entrylo1_n  = entrylo1_q;

        if (cp0_wr.we) begin
            case (cp0_wr.addr)
                cp0_index: begin
                    index_p_n   = cp0_wr.data[31];
                    index_idx_n = cp0_wr.data[idx_w-1:0];
                end
                cp0_entryhi:  entryhi_n  = cp0_wr.data & entryhi_mask;
                cp0_entrylo0: entrylo0_n = cp0_wr.data & entrylo_mask;
                cp0_entrylo1: entrylo1_n = cp0_wr.data & entrylo_mask;
                // random is read-only
                default: ;
            endcase
        end

        if (tlb_cmd_valid) begin
            case (tlb_cmd_op)
                tlbwr: begin
                    if (random_q == '0) begin
                        random_n = idx_w'(tlb_entries - 1);
                    end else begin
                        random_n = random_q - 1'b1;
                    end
                end
                tlbr: begin
                    entryhi_n  = {r_entry.vpn2, 5'b0, r_entry.asid};
                    entrylo0_n = {6'b0, r_entry.even, r_entry.g};
                    entrylo1_n = {6'b0, r_entry.odd, r_entry.g};
                end
                default: ;
            endcase
        end

        // probe result lands one cycle after the tlbp strobe
        if (probe_pending) begin
            index_p_n   = !probe_res.found;
            index_idx_n = probe_res.found ? probe_res.index[idx_w-1:0] : '0;
        end
    end

    // move-from sees this edge's update
    always_comb begin
        case (cp0_rd_addr)
            cp0_index:    rd_next = {index_p_n, 31'(index_idx_n)};
            cp0_random:   rd_next = 32'(random_n);
            cp0_entrylo0: rd_next = entrylo0_n;
            cp0_entrylo1: rd_next = entrylo1_n;
            cp0_entryhi:  rd_next = entryhi_n;
            default:      rd_next = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            index_p       <= 1'b0;
            index_idx     <= '0;
            random_q      <= idx_w'(tlb_entries - 1);
            entryhi_q     <= '0;
            entrylo0_q    <= '0;
            entrylo1_q    <= '0;
            probe_pending <= 1'b0;
            cp0_rd_data   <= '0;
        end else begin
            index_p       <= index_p_n;
            index_idx     <= index_idx_n;
            random_q      <= random_n;
            entryhi_q     <= entryhi_n;
            entrylo0_q    <= entrylo0_n;
            entrylo1_q    <= entrylo1_n;
            probe_pending <= probe_req.valid;
            cp0_rd_data   <= rd_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/tlb_search.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_search #(
    parameter int tlb_entries = 16
) (
    input  wire logic                aclk,
    input  wire logic                rst_n,
    input  wire tlb_pkg::tlb_entry_t entries [tlb_entries],
    input  wire tlb_pkg::asid_t      asid,
    input  wire tlb_pkg::tlb_req_t   req,
    output tlb_pkg::tlb_res_t        res
);

    import tlb_pkg::*;

    localparam int idx_w = $clog2(tlb_entries);

    logic [tlb_entries-1:0] hit;
    logic                   found;
    logic [idx_w-1:0]       hit_idx;
    tlb_page_t              page;
    tlb_res_t               res_next;

    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            hit[i] = (entries[i].vpn2 == req.vpn2) &&
                     (entries[i].g || (entries[i].asid == asid));
        end
    end

    // scan from the top so the lowest hit is assigned last
    always_comb begin
        hit_idx = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_idx = idx_w'(i);
            end
        end
    end

    assign found = |hit;
    assign page  = req.odd ? entries[hit_idx].odd : entries[hit_idx].even;

    always_comb begin
        res_next       = '0;
        res_next.valid = req.valid;
        if (req.valid && found) begin
            res_next.found = 1'b1;
            res_next.index = res_index_w'(hit_idx);
            res_next.pfn   = page.pfn;
            res_next.c     = page.c;
            res_next.d     = page.d;
            res_next.v     = page.v;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            res <= '0;
        end else begin
            res <= res_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/tlb_array.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_array #(
    parameter int tlb_entries = 16
) (
    input  wire logic                           aclk,
    input  wire logic                           rst_n,
    input  wire logic                           we,
    input  wire logic [$clog2(tlb_entries)-1:0] w_index,
    input  wire tlb_pkg::tlb_entry_t            w_entry,
    input  wire logic [$clog2(tlb_entries)-1:0] r_index,
    output tlb_pkg::tlb_entry_t                 r_entry,
    output tlb_pkg::tlb_entry_t                 entries [tlb_entries]
);

    import tlb_pkg::*;

    // every entry comes out of reset invalid and all-zero
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < tlb_entries; i++) begin
                entries[i] <= '0;
            end
        end else if (we) begin
            entries[w_index] <= w_entry;
        end
    end

    // combinational read for tlbr
    always_comb begin
        r_entry = entries[r_index];
    end

endmodule

`default_nettype wire

//--- hdl/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

    typedef enum logic [4:0] {
        cp0_index    = 5'd0,
        cp0_random   = 5'd1,
        cp0_entrylo0 = 5'd2,
        cp0_entrylo1 = 5'd3,
        cp0_entryhi  = 5'd10
    } cp0_reg_e;

    typedef enum logic [1:0] {
        tlbwi = 2'd0,
        tlbwr = 2'd1,
        tlbr  = 2'd2,
        tlbp  = 2'd3
    } tlb_op_e;

    // vpn2 in 31:13, asid in 7:0
    localparam logic [31:0] entryhi_mask = 32'hffff_e0ff;
    // pfn, c, d, v, g
    localparam logic [31:0] entrylo_mask = 32'h03ff_ffff;

    typedef struct packed {
        logic        we;
        cp0_reg_e    addr;
        logic [31:0] data;
    } cp0_wr_t;

endpackage

`default_nettype wire

//--- hdl/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    localparam int vpn2_w      = 19;
    localparam int asid_w      = 8;
    localparam int pfn_w       = 20;
    localparam int cattr_w     = 3;
    // wide enough for any supported entry count
    localparam int res_index_w = 8;

    typedef logic [vpn2_w-1:0]  vpn2_t;
    typedef logic [asid_w-1:0]  asid_t;
    typedef logic [pfn_w-1:0]   pfn_t;
    typedef logic [cattr_w-1:0] cattr_t;

    // one half of a page pair
    typedef struct packed {
        pfn_t   pfn;
        cattr_t c;
        logic   d;
        logic   v;
    } tlb_page_t;

    typedef struct packed {
        vpn2_t     vpn2;
        asid_t     asid;
        logic      g;
        tlb_page_t even;
        tlb_page_t odd;
    } tlb_entry_t;

    typedef struct packed {
        logic  valid;
        vpn2_t vpn2;
        logic  odd;
    } tlb_req_t;

    typedef struct packed {
        logic                   valid;
        logic                   found;
        logic [res_index_w-1:0] index;
        pfn_t                   pfn;
        cattr_t                 c;
        logic                   d;
        logic                   v;
    } tlb_res_t;

endpackage

`default_nettype wire
